//--- vga_term_pkg.sv
package vga_term_pkg;

	// 640x480 at 60 Hz, pixel clock is clk
	localparam int h_visible = 640;
	localparam int h_front = 16;
	localparam int h_sync = 96;
	localparam int h_back = 48;
	localparam int h_total = h_visible + h_front + h_sync + h_back;

	localparam int v_visible = 480;
	localparam int v_front = 10;
	localparam int v_sync = 2;
	localparam int v_back = 33;
	localparam int v_total = v_visible + v_front + v_sync + v_back;

	// 8x16 cells
	localparam int cols = 80;
	localparam int rows = 30;
	localparam int buf_depth = cols * rows;
	localparam int buf_addr_w = 12;

	localparam logic [11:0] reg_cursor_addr = 12'hFFC;
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// set 2 scan codes with special meaning
	localparam logic [7:0] key_break = 8'hF0;
	localparam logic [7:0] key_enter = 8'h5A;
	localparam logic [7:0] char_space = 8'h20;

	typedef logic [7:0] char_t;

	typedef struct packed {
		logic valid;
		logic write;
		logic [buf_addr_w-1:0] addr;
		char_t data;
	} buf_req_t;

	typedef struct packed {
		logic valid;
		char_t data;
	} buf_rsp_t;

	typedef struct packed {
		logic [11:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [11:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
	} axil_r_t;

endpackage

//--- ps2_rx.sv
module ps2_rx (
	input  logic clk,
	input  logic arst_n,
	input  logic ps2_clk,
	input  logic ps2_data,
	output vga_term_pkg::char_t code,
	output logic code_valid
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic clk_prev;
	logic fall;
	logic [10:0] frame;
	logic [3:0] bit_cnt;
	logic done;
	logic ok;

	assign fall = clk_prev && !clk_sync[1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
			bit_cnt <= 4'd0;
			done <= 1'b0;
			ok <= 1'b0;
			code_valid <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
			done <= 1'b0;
			if (fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= 4'd0;
					done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
			// start 0, stop 1, odd parity over data and parity bit
			ok <= done && !frame[0] && frame[10] && (^frame[9:1]);
			code_valid <= ok;
		end
	end

	// lsb first, so the frame shifts in from the top
	always_ff @(posedge clk) begin
		if (fall) begin
			frame <= {data_sync[1], frame[10:1]};
		end
		if (done) begin
			code <= frame[8:1];
		end
	end

endmodule

//--- char_writer.sv
module char_writer (
	input  logic clk,
	input  logic arst_n,
	input  vga_term_pkg::char_t code,
	input  logic code_valid,
	output vga_term_pkg::buf_req_t req,
	input  logic gnt,
	output logic [11:0] cursor
);

	logic brk;
	logic [6:0] col;
	logic req_valid;
	logic [11:0] req_addr;
	vga_term_pkg::char_t req_data;
	vga_term_pkg::char_t ascii;
	logic take;
	logic [11:0] step;
	logic [11:0] enter_next;

	function automatic vga_term_pkg::char_t to_ascii(input vga_term_pkg::char_t sc);
		case (sc)
			8'h1C: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2B: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3B: return "j";
			8'h42: return "k";
			8'h4B: return "l";
			8'h3A: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4D: return "p";
			8'h15: return "q";
			8'h2D: return "r";
			8'h1B: return "s";
			8'h2C: return "t";
			8'h3C: return "u";
			8'h2A: return "v";
			8'h1D: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1A: return "z";
			8'h45: return "0";
			8'h16: return "1";
			8'h1E: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2E: return "5";
			8'h36: return "6";
			8'h3D: return "7";
			8'h3E: return "8";
			8'h46: return "9";
			8'h29: return " ";
			default: return 8'h00;
		endcase
	endfunction

	assign ascii = to_ascii(code);
	assign take = code_valid && !req_valid;
	assign step = cursor + 12'(vga_term_pkg::cols) - {5'd0, col};
	assign enter_next = (step >= 12'(vga_term_pkg::buf_depth)) ? 12'd0 : step;
	assign req = '{valid: req_valid, write: 1'b1, addr: req_addr, data: req_data};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			brk <= 1'b0;
			col <= 7'd0;
			cursor <= 12'd0;
			req_valid <= 1'b0;
		end else if (gnt) begin
			req_valid <= 1'b0;
			if (cursor == 12'(vga_term_pkg::buf_depth - 1)) begin
				cursor <= 12'd0;
			end else begin
				cursor <= cursor + 12'd1;
			end
			col <= (col == 7'(vga_term_pkg::cols - 1)) ? 7'd0 : col + 7'd1;
		end else if (take) begin
			// code after F0 is the break of a key already handled
			if (code == vga_term_pkg::key_break) begin
				brk <= 1'b1;
			end else if (brk) begin
				brk <= 1'b0;
			end else if (code == vga_term_pkg::key_enter) begin
				cursor <= enter_next;
				col <= 7'd0;
			end else if (ascii != 8'h00) begin
				req_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			req_addr <= cursor;
			req_data <= ascii;
		end
	end

endmodule

//--- axil_text_port.sv
module axil_text_port (
	input  logic clk,
	input  logic arst_n,
	input  vga_term_pkg::axil_aw_t aw,
	input  logic awvalid,
	output logic awready,
	input  vga_term_pkg::axil_w_t w,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  vga_term_pkg::axil_ar_t ar,
	input  logic arvalid,
	output logic arready,
	output vga_term_pkg::axil_r_t r,
	output logic rvalid,
	input  logic rready,
	output vga_term_pkg::buf_req_t req,
	input  logic gnt,
	input  vga_term_pkg::buf_rsp_t rsp,
	input  logic [11:0] cursor
);

	typedef enum logic [2:0] {st_idle, st_req, st_rd_wait, st_bresp, st_rresp} state_t;

	state_t state;
	logic up;
	logic rd_go;
	logic wr_ok;
	logic rd_ok;
	logic rd_cur;
	logic req_valid;
	logic req_write;
	logic [11:0] req_addr;
	vga_term_pkg::char_t req_data;

	function automatic logic in_buf(input logic [11:0] a);
		return (a != vga_term_pkg::reg_cursor_addr) && (int'(a) < vga_term_pkg::buf_depth * 4);
	endfunction

	// AW and W are only taken as a pair
	assign awready = up && (state == st_idle) && awvalid && wvalid;
	assign wready = awready;
	assign arready = up && (state == st_idle) && !(awvalid && wvalid);
	assign rd_go = arready && arvalid;
	assign bvalid = (state == st_bresp);
	assign rvalid = (state == st_rresp);

	assign wr_ok = in_buf(aw.addr);
	assign rd_ok = in_buf(ar.addr);
	assign rd_cur = (ar.addr == vga_term_pkg::reg_cursor_addr);
	assign req = '{valid: req_valid, write: req_write, addr: req_addr, data: req_data};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			up <= 1'b0;
			state <= st_idle;
			req_valid <= 1'b0;
		end else begin
			up <= 1'b1;
			case (state)
				st_idle: begin
					if (awready) begin
						// skipped writes still get a response
						req_valid <= wr_ok && w.strb[0];
						state <= (wr_ok && w.strb[0]) ? st_req : st_bresp;
					end else if (rd_go) begin
						req_valid <= rd_ok;
						state <= rd_ok ? st_req : st_rresp;
					end
				end
				st_req: begin
					if (gnt) begin
						req_valid <= 1'b0;
						state <= req_write ? st_bresp : st_rd_wait;
					end
				end
				st_rd_wait: begin
					if (rsp.valid) begin
						state <= st_rresp;
					end
				end
				st_bresp: begin
					if (bready) begin
						state <= st_idle;
					end
				end
				default: begin
					if (rready) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (awready) begin
			req_write <= 1'b1;
			req_addr <= {2'b00, aw.addr[11:2]};
			req_data <= w.data[7:0];
			bresp <= wr_ok ? vga_term_pkg::resp_okay : vga_term_pkg::resp_slverr;
		end else if (rd_go) begin
			req_write <= 1'b0;
			req_addr <= {2'b00, ar.addr[11:2]};
			r.resp <= (rd_ok || rd_cur) ? vga_term_pkg::resp_okay : vga_term_pkg::resp_slverr;
			r.data <= rd_cur ? {20'd0, cursor} : 32'd0;
		end else if (state == st_rd_wait && rsp.valid) begin
			r.data <= {24'd0, rsp.data};
		end
	end

endmodule

//--- text_buf.sv
module text_buf (
	input  logic clk,
	input  logic arst_n,
	input  vga_term_pkg::buf_req_t wr_req,
	output logic wr_gnt,
	input  vga_term_pkg::buf_req_t host_req,
	output logic host_gnt,
	output vga_term_pkg::buf_rsp_t host_rsp,
	input  logic [vga_term_pkg::buf_addr_w-1:0] vid_addr,
	output vga_term_pkg::char_t vid_data
);

	vga_term_pkg::char_t mem [vga_term_pkg::buf_depth];

	logic clr_busy;
	logic [11:0] clr_addr;
	logic ptr;
	vga_term_pkg::buf_req_t sel;
	logic we;
	logic [11:0] waddr;
	vga_term_pkg::char_t wdata;
	logic rd_en;
	logic rsp_valid;
	vga_term_pkg::char_t rsp_data;

	// ptr high means the host port goes first on a tie
	assign wr_gnt = !clr_busy && wr_req.valid && (!host_req.valid || !ptr);
	assign host_gnt = !clr_busy && host_req.valid && (!wr_req.valid || ptr);
	assign sel = host_gnt ? host_req : wr_req;

	assign we = clr_busy || ((wr_gnt || host_gnt) && sel.write);
	assign waddr = clr_busy ? clr_addr : sel.addr;
	assign wdata = clr_busy ? vga_term_pkg::char_space : sel.data;
	assign rd_en = host_gnt && !host_req.write;
	assign host_rsp = '{valid: rsp_valid, data: rsp_data};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clr_busy <= 1'b1;
			clr_addr <= 12'd0;
			ptr <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			if (clr_busy) begin
				if (clr_addr == 12'(vga_term_pkg::buf_depth - 1)) begin
					clr_busy <= 1'b0;
				end else begin
					clr_addr <= clr_addr + 12'd1;
				end
			end
			if (wr_gnt) begin
				ptr <= 1'b1;
			end else if (host_gnt) begin
				ptr <= 1'b0;
			end
			rsp_valid <= rd_en;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		if (rd_en) begin
			rsp_data <= mem[sel.addr];
		end
		vid_data <= mem[vid_addr];
	end

endmodule

//--- vga_text_scan.sv
module vga_text_scan (
	input  logic clk,
	input  logic arst_n,
	output logic [11:0] vid_addr,
	input  vga_term_pkg::char_t vid_data,
	output logic [10:0] font_addr,
	input  logic [7:0] font_row,
	output logic hsync,
	output logic vsync,
	output logic blank_n,
	output logic [23:0] rgb
);

	typedef struct packed {
		logic hs;
		logic vs;
		logic vis;
		logic [2:0] px;
		logic [3:0] ln;
	} stage_t;

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic [11:0] cell_addr;
	stage_t s0;
	stage_t s1;
	stage_t s2;

	always_comb begin
		s0.hs = !((h_cnt >= 10'(vga_term_pkg::h_visible + vga_term_pkg::h_front)) &&
			(h_cnt < 10'(vga_term_pkg::h_visible + vga_term_pkg::h_front + vga_term_pkg::h_sync)));
		s0.vs = !((v_cnt >= 10'(vga_term_pkg::v_visible + vga_term_pkg::v_front)) &&
			(v_cnt < 10'(vga_term_pkg::v_visible + vga_term_pkg::v_front + vga_term_pkg::v_sync)));
		s0.vis = (h_cnt < 10'(vga_term_pkg::h_visible)) && (v_cnt < 10'(vga_term_pkg::v_visible));
		s0.px = h_cnt[2:0];
		s0.ln = v_cnt[3:0];
	end

	// row * cols + column, only inside the visible area
	assign cell_addr = 12'(v_cnt[8:4]) * 12'(vga_term_pkg::cols) + 12'(h_cnt[9:3]);
	assign vid_addr = s0.vis ? cell_addr : 12'd0;
	assign font_addr = {vid_data[6:0], s1.ln};

	assign hsync = s2.hs;
	assign vsync = s2.vs;
	assign blank_n = s2.vis;
	assign rgb = (s2.vis && font_row[3'd7 - s2.px]) ? 24'hFFFFFF : 24'h000000;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= 10'd0;
			v_cnt <= 10'd0;
		end else if (h_cnt == 10'(vga_term_pkg::h_total - 1)) begin
			h_cnt <= 10'd0;
			if (v_cnt == 10'(vga_term_pkg::v_total - 1)) begin
				v_cnt <= 10'd0;
			end else begin
				v_cnt <= v_cnt + 10'd1;
			end
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	// buffer read, then font read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1 <= '{hs: 1'b1, vs: 1'b1, default: '0};
			s2 <= '{hs: 1'b1, vs: 1'b1, default: '0};
		end else begin
			s1 <= s0;
			s2 <= s1;
		end
	end

endmodule

//--- vga_terminal_top.sv
module vga_terminal_top (
	input  logic clk,
	input  logic arst_n,
	input  logic ps2_clk,
	input  logic ps2_data,
	input  vga_term_pkg::axil_aw_t aw,
	input  logic awvalid,
	output logic awready,
	input  vga_term_pkg::axil_w_t w,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  vga_term_pkg::axil_ar_t ar,
	input  logic arvalid,
	output logic arready,
	output vga_term_pkg::axil_r_t r,
	output logic rvalid,
	input  logic rready,
	output logic [10:0] font_addr,
	input  logic [7:0] font_row,
	output logic hsync,
	output logic vsync,
	output logic blank_n,
	output logic [23:0] rgb
);

	vga_term_pkg::char_t code;
	logic code_valid;
	vga_term_pkg::buf_req_t wr_req;
	logic wr_gnt;
	vga_term_pkg::buf_req_t host_req;
	logic host_gnt;
	vga_term_pkg::buf_rsp_t host_rsp;
	logic [11:0] cursor;
	logic [11:0] vid_addr;
	vga_term_pkg::char_t vid_data;

	ps2_rx u_ps2_rx (
		.clk(clk),
		.arst_n(arst_n),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.code(code),
		.code_valid(code_valid)
	);

	char_writer u_char_writer (
		.clk(clk),
		.arst_n(arst_n),
		.code(code),
		.code_valid(code_valid),
		.req(wr_req),
		.gnt(wr_gnt),
		.cursor(cursor)
	);

	axil_text_port u_axil_text_port (
		.clk(clk),
		.arst_n(arst_n),
		.aw(aw),
		.awvalid(awvalid),
		.awready(awready),
		.w(w),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.ar(ar),
		.arvalid(arvalid),
		.arready(arready),
		.r(r),
		.rvalid(rvalid),
		.rready(rready),
		.req(host_req),
		.gnt(host_gnt),
		.rsp(host_rsp),
		.cursor(cursor)
	);

	text_buf u_text_buf (
		.clk(clk),
		.arst_n(arst_n),
		.wr_req(wr_req),
		.wr_gnt(wr_gnt),
		.host_req(host_req),
		.host_gnt(host_gnt),
		.host_rsp(host_rsp),
		.vid_addr(vid_addr),
		.vid_data(vid_data)
	);

	vga_text_scan u_vga_text_scan (
		.clk(clk),
		.arst_n(arst_n),
		.vid_addr(vid_addr),
		.vid_data(vid_data),
		.font_addr(font_addr),
		.font_row(font_row),
		.hsync(hsync),
		.vsync(vsync),
		.blank_n(blank_n),
		.rgb(rgb)
	);

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held over the first two rising edges
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		arst_n = 1'b1;
	end

endmodule

//--- tb_vga_terminal.sv
module tb_vga_terminal;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int line_cycles = 800;
	localparam int frame_lines = 525;
	localparam int hsync_cycles = 96;
	localparam int vsync_lines = 2;
	localparam int bit_cycles = 2500;
	localparam int half_bit = bit_cycles / 2;
	localparam int clear_cycles = 2400;
	localparam int row_cycles = 2000;
	localparam int num_rows = 24;

	typedef enum logic [2:0] {k_key, k_bad_key, k_wr, k_rd, k_cur, k_key_wr} kind_t;

	typedef struct packed {
		kind_t kind;
		logic [15:0] value;
		logic [11:0] addr;
		logic [31:0] exp_val;
	} row_t;

	// key rows carry the scan code in value, k_key_wr has it in the high byte
	localparam row_t stim [num_rows] = '{
		'{k_rd, 16'h0000, 12'hFA0, 32'h20},
		'{k_wr, 16'h004B, 12'h148, 32'h0},
		'{k_wr, 16'h007E, 12'h190, 32'h0},
		'{k_rd, 16'h0000, 12'h148, 32'h4B},
		'{k_rd, 16'h0000, 12'h190, 32'h7E},
		'{k_wr, 16'h0005, 12'hFFC, 32'h2},
		'{k_cur, 16'h0000, 12'hFFC, 32'h0},
		'{k_key, 16'h001C, 12'h000, 32'h0},
		'{k_key, 16'h0032, 12'h000, 32'h0},
		'{k_bad_key, 16'h0021, 12'h000, 32'h0},
		'{k_key, 16'h0016, 12'h000, 32'h0},
		'{k_cur, 16'h0000, 12'hFFC, 32'h3},
		'{k_rd, 16'h0000, 12'h000, 32'h61},
		'{k_rd, 16'h0000, 12'h004, 32'h62},
		'{k_rd, 16'h0000, 12'h008, 32'h31},
		'{k_rd, 16'h0000, 12'h00C, 32'h20},
		'{k_key, 16'h005A, 12'h000, 32'h0},
		'{k_cur, 16'h0000, 12'hFFC, 32'h50},
		'{k_key, 16'h001A, 12'h000, 32'h0},
		'{k_rd, 16'h0000, 12'h140, 32'h7A},
		'{k_key_wr, 16'h4451, 12'h320, 32'h0},
		'{k_rd, 16'h0000, 12'h144, 32'h6F},
		'{k_rd, 16'h0000, 12'h320, 32'h51},
		'{k_cur, 16'h0000, 12'hFFC, 32'h52}
	};

	logic clk;
	logic arst_n;
	logic ps2_clk;
	logic ps2_data;
	vga_term_pkg::axil_aw_t aw;
	logic awvalid;
	logic awready;
	vga_term_pkg::axil_w_t w;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	vga_term_pkg::axil_ar_t ar;
	logic arvalid;
	logic arready;
	vga_term_pkg::axil_r_t r;
	logic rvalid;
	logic rready;
	logic [10:0] font_addr;
	logic [7:0] font_row;
	logic hsync;
	logic vsync;
	logic blank_n;
	logic [23:0] rgb;
	logic [10:0] fa;
	int cycles = 0;
	int limit = 0;

	tb_clk_gen u_clk_gen (.clk(clk), .arst_n(arst_n));

	vga_terminal_top UUT (
		.clk(clk),
		.arst_n(arst_n),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.aw(aw),
		.awvalid(awvalid),
		.awready(awready),
		.w(w),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.ar(ar),
		.arvalid(arvalid),
		.arready(arready),
		.r(r),
		.rvalid(rvalid),
		.rready(rready),
		.font_addr(font_addr),
		.font_row(font_row),
		.hsync(hsync),
		.vsync(vsync),
		.blank_n(blank_n),
		.rgb(rgb)
	);

	// font model: (code ^ row) << 1
	function automatic logic [7:0] glyph(input logic [6:0] ch, input logic [3:0] ln);
		return {ch ^ {3'b000, ln}, 1'b0};
	endfunction

	function automatic int ps2_frames();
		int n;
		logic [4:0] idx;
		n = 0;
		for (idx = 0; idx < 5'(num_rows); idx++) begin
			case (stim[idx].kind)
				k_key, k_key_wr: n += 3;
				k_bad_key: n += 1;
				default: n += 0;
			endcase
		end
		return n;
	endfunction

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error: %s is %h, expected %h", name, actual, expected);
			$display("** FAIL **");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	// leaves ps2_clk low right after the stop bit's falling edge
	task automatic send_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		int i;
		bits = {1'b1, ~^code ^ bad_parity, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			ps2_data = bits[0];
			bits = bits >> 1;
			repeat (half_bit) step();
			ps2_clk = 1'b0;
			if (i < 10) begin
				repeat (half_bit) step();
				ps2_clk = 1'b1;
			end
		end
	endtask

	task automatic end_frame();
		repeat (half_bit) step();
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		repeat (bit_cycles) step();
	endtask

	task automatic press_key(input logic [7:0] code, input logic bad_parity);
		send_frame(code, bad_parity);
		end_frame();
		if (!bad_parity) begin
			send_frame(8'hF0, 1'b0);
			end_frame();
			send_frame(code, 1'b0);
			end_frame();
		end
	endtask

	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int gap;
		aw = '{addr: addr};
		w = '{data: data, strb: 4'hF};
		awvalid = 1'b1;
		wvalid = 1'b1;
		do @(negedge clk); while (!awready);
		compare("wready", 32'(wready), 32'h1);
		step();
		awvalid = 1'b0;
		wvalid = 1'b0;
		gap = $urandom_range(3, 0);
		repeat (gap) step();
		bready = 1'b1;
		do @(negedge clk); while (!bvalid);
		resp = bresp;
		step();
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int gap;
		ar = '{addr: addr};
		arvalid = 1'b1;
		do @(negedge clk); while (!arready);
		step();
		arvalid = 1'b0;
		gap = $urandom_range(3, 0);
		repeat (gap) step();
		rready = 1'b1;
		do @(negedge clk); while (!rvalid);
		data = r.data;
		resp = r.resp;
		step();
		rready = 1'b0;
	endtask

	// falling edge to falling edge of hsync or vsync
	task automatic measure_sync(input logic use_v, output int period, output int low);
		logic prev;
		logic s;
		s = 1'b0;
		prev = 1'b0;
		do begin
			prev = s;
			@(negedge clk);
			s = use_v ? vsync : hsync;
		end while (!(prev && !s));
		period = 0;
		low = 0;
		do begin
			if (!s) low++;
			period++;
			prev = s;
			@(negedge clk);
			s = use_v ? vsync : hsync;
		end while (!(prev && !s));
	endtask

	// lines counted by blank_n rises after vsync, pixels by blank_n high cycles
	task automatic check_glyph_row(input int col, input int cell_row, input logic [3:0] ln,
		input logic [7:0] ch);
		int y;
		int line;
		int i;
		logic [7:0] bits;
		y = cell_row * 16 + int'(ln);
		do @(negedge clk); while (vsync);
		do @(negedge clk); while (!vsync);
		for (line = 0; line <= y; line++) begin
			do @(negedge clk); while (!blank_n);
			if (line < y) begin
				do @(negedge clk); while (blank_n);
			end
		end
		repeat (col * 8) @(negedge clk);
		bits = glyph(ch[6:0], ln);
		for (i = 0; i < 8; i++) begin
			compare("rgb", 32'(rgb), bits[7] ? 32'hFFFFFF : 32'h0);
			bits = bits << 1;
			@(negedge clk);
		end
	endtask

	// external font ROM, one cycle read
	initial begin
		font_row = 8'h00;
		forever begin
			@(negedge clk);
			fa = font_addr;
			@(posedge clk);
			#2;
			font_row = glyph(fa[10:4], fa[3:0]);
		end
	end

	always @(negedge clk) begin
		if (arst_n && !blank_n) begin
			compare("rgb", 32'(rgb), 32'h0);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit && limit != 0) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic [4:0] idx;
		row_t row;
		logic [31:0] data;
		logic [1:0] resp;
		int period;
		int low;
		limit = 3 * line_cycles * frame_lines + clear_cycles + num_rows * row_cycles
			+ ps2_frames() * 12 * bit_cycles;
		void'($urandom(32'hcec9_3354));
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		aw = '0;
		awvalid = 1'b0;
		w = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		ar = '0;
		arvalid = 1'b0;
		rready = 1'b0;

		@(posedge arst_n);
		@(negedge clk);
		compare("awready", 32'(awready), 32'h0);
		compare("arready", 32'(arready), 32'h0);
		compare("bvalid", 32'(bvalid), 32'h0);
		compare("rvalid", 32'(rvalid), 32'h0);
		compare("hsync", 32'(hsync), 32'h1);
		compare("vsync", 32'(vsync), 32'h1);
		compare("blank_n", 32'(blank_n), 32'h0);
		@(negedge clk);
		compare("arready", 32'(arready), 32'h1);

		// buffer clearing sweep
		repeat (clear_cycles) step();

		for (idx = 0; idx < 5'(num_rows); idx++) begin
			row = stim[idx];
			case (row.kind)
				k_key: press_key(row.value[7:0], 1'b0);
				k_bad_key: press_key(row.value[7:0], 1'b1);
				k_wr: begin
					axi_write(row.addr, {24'd0, row.value[7:0]}, resp);
					compare("bresp", 32'(resp), row.exp_val);
				end
				k_rd, k_cur: begin
					axi_read(row.addr, data, resp);
					compare("rdata", data, row.exp_val);
					compare("rresp", 32'(resp), 32'h0);
				end
				k_key_wr: begin
					send_frame(row.value[15:8], 1'b0);
					// host request lands in the same cycle as the writer's
					repeat (5) step();
					axi_write(row.addr, {24'd0, row.value[7:0]}, resp);
					compare("bresp", 32'(resp), row.exp_val);
					end_frame();
					send_frame(8'hF0, 1'b0);
					end_frame();
					send_frame(row.value[15:8], 1'b0);
					end_frame();
				end
				default: begin
					$display("the stimulus table holds a row of unknown kind");
					$display("** FAIL **");
					$fatal(1, "bad table row");
				end
			endcase
		end

		measure_sync(1'b0, period, low);
		compare("hsync period", 32'(period), 32'(line_cycles));
		compare("hsync low", 32'(low), 32'(hsync_cycles));
		measure_sync(1'b1, period, low);
		compare("vsync period", 32'(period), 32'(frame_lines * line_cycles));
		compare("vsync low", 32'(low), 32'(vsync_lines * line_cycles));

		// cell 100 holds 7E from the table
		check_glyph_row(20, 1, 4'd5, 8'h7E);

		$display("** PASS **");
		$finish;
	end

endmodule

//--- sim.f
vga_term_pkg.sv
ps2_rx.sv
char_writer.sv
axil_text_port.sv
text_buf.sv
vga_text_scan.sv
vga_terminal_top.sv
tb_clk_gen.sv
tb_vga_terminal.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --timing --timescale 1ns/100ps
TOP = tb_vga_terminal
RTL_TOP = vga_terminal_top
FILELIST = sim.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS = ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
